//--- hw/raycast_pkg.sv
`default_nettype none

package raycast_pkg;

    typedef logic [8:0]  hcount_t;    // screen column
    typedef logic [7:0]  row_t;       // row within a column
    typedef logic [15:0] fb_addr_t;   // frame-buffer word address
    typedef logic [7:0]  color_t;     // palette index
    typedef logic [4:0]  map_cell_t;  // raw map cell value

    typedef enum logic [1:0] {HEDGE, PIGS, DINO, NEON} map_select_e;
    typedef enum logic [1:0] {CEILING, FLOOR, WALL} region_e;

    // one record from the wall-distance FIFO, msb first
    typedef struct packed {
        hcount_t     hcount;
        logic [7:0]  line_height;
        logic        wall_type;    // 0 = x side hit, 1 = y side hit
        map_cell_t   map_data;
        logic [15:0] wall_x;       // texture offset, unused here
    } column_rec_t;

    typedef struct packed {
        logic       valid;
        hcount_t    hcount;
        row_t       row;
        logic [7:0] line_height;
        logic       wall_type;
        map_cell_t  map_data;
        logic       last;          // final row of a packet-closing record
    } sweep_beat_t;

    typedef struct packed {
        logic    valid;
        hcount_t hcount;
        row_t    row;
        logic    last;
        region_e region;
    } span_result_t;

    typedef struct packed {
        logic   shade;
        color_t color;
    } fb_pixel_t;

    // per-row colour candidates, picked by region downstream
    typedef struct packed {
        color_t sky;
        color_t ground;
        color_t wall_color;
        logic   shade;
    } palette_t;

    localparam color_t SKY_HEDGE    = 8'd249;
    localparam color_t GROUND_HEDGE = 8'd239;
    localparam color_t SKY_DAY      = 8'd38;   // pigs and dino share these
    localparam color_t GROUND_DAY   = 8'd45;
    localparam color_t SKY_NEON     = 8'd255;
    localparam color_t GROUND_NEON  = 8'd255;
    localparam color_t SOLID_WALL   = 8'd14;
    localparam color_t NEON_YELLOW  = 8'd21;
    localparam color_t NEON_BLUE    = 8'd48;
    localparam color_t NEON_GREEN   = 8'd32;
    localparam color_t NEON_PINK    = 8'd181;

endpackage

`default_nettype wire

//--- hw/column_intake.sv
`timescale 1ns/10ps
`default_nettype none

module column_intake #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  wire                      pixel_clk_in,
    input  wire                      rst_in,
    input  wire                      column_tvalid,
    input  wire raycast_pkg::column_rec_t column_tdata,
    input  wire                      column_tlast,
    input  wire                      fb_switch_ready,
    output logic                     column_tready,
    output raycast_pkg::sweep_beat_t beat
);

    localparam raycast_pkg::row_t LAST_ROW = raycast_pkg::row_t'(SCREEN_HEIGHT - 1);

    typedef enum logic [1:0] {
        ST_WAIT_REC,     // ready high, waiting on the FIFO
        ST_SWEEP,        // one beat per cycle, row 0 upward
        ST_WAIT_SWITCH   // packet done, hold off until fb swaps
    } state_t;

    state_t                   state;
    raycast_pkg::row_t        row_cnt;
    raycast_pkg::column_rec_t rec_q;   // accepted record
    logic                     tlast_q; // record closed a packet

    wire accept   = column_tvalid && column_tready;
    wire row_last = (row_cnt == LAST_ROW);

    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            rec_q   <= column_tdata;
            tlast_q <= column_tlast;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state         <= ST_WAIT_REC;
            column_tready <= 1'b1;
            row_cnt       <= '0;
        end else begin
            case (state)
                ST_WAIT_REC: begin
                    if (accept) begin
                        state         <= ST_SWEEP;
                        column_tready <= 1'b0; // drops the cycle after acceptance
                        row_cnt       <= '0;
                    end
                end
                ST_SWEEP: begin
                    if (row_last) begin
                        row_cnt <= '0;
                        if (tlast_q) begin
                            state <= ST_WAIT_SWITCH; // tready stays low
                        end else begin
                            state         <= ST_WAIT_REC;
                            column_tready <= 1'b1;
                        end
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                ST_WAIT_SWITCH: begin
                    if (fb_switch_ready) begin
                        state         <= ST_WAIT_REC;
                        column_tready <= 1'b1; // up in the next cycle
                    end
                end
                default: state <= ST_WAIT_REC;
            endcase
        end
    end

    // beat straight from the sweep registers
    always_comb begin
        beat.valid       = (state == ST_SWEEP);
        beat.hcount      = rec_q.hcount;
        beat.row         = row_cnt;
        beat.line_height = rec_q.line_height;
        beat.wall_type   = rec_q.wall_type;
        beat.map_data    = rec_q.map_data;
        beat.last        = (state == ST_SWEEP) && row_last && tlast_q;
    end

endmodule

`default_nettype wire

//--- hw/span_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module span_classifier #(
    parameter int SCREEN_HEIGHT = 180
) (
    input  wire                        pixel_clk_in,
    input  wire                        rst_in,
    input  wire raycast_pkg::sweep_beat_t beat,
    output raycast_pkg::span_result_t  span
);

    localparam raycast_pkg::row_t HALF_H  = raycast_pkg::row_t'(SCREEN_HEIGHT / 2);
    localparam logic [8:0]        END_MAX = 9'(SCREEN_HEIGHT);

    logic [7:0]          half_len;
    raycast_pkg::row_t   draw_start;
    logic [8:0]          end_sum;   // one extra bit before clamping
    logic [8:0]          draw_end;
    raycast_pkg::region_e region;

    always_comb begin
        half_len   = beat.line_height >> 1;
        // clamp at the top edge
        draw_start = (half_len > HALF_H) ? '0 : HALF_H - half_len;
        end_sum    = {1'b0, HALF_H} + {1'b0, half_len};
        draw_end   = (end_sum > END_MAX) ? END_MAX : end_sum; // and at the bottom
        if (beat.row < draw_start) begin
            region = raycast_pkg::CEILING;
        end else if ({1'b0, beat.row} >= draw_end) begin
            region = raycast_pkg::FLOOR;
        end else begin
            region = raycast_pkg::WALL;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        span.hcount <= beat.hcount;
        span.row    <= beat.row;
        span.region <= region;
        if (rst_in) begin
            span.valid <= 1'b0;
            span.last  <= 1'b0;
        end else begin
            span.valid <= beat.valid;
            span.last  <= beat.last;
        end
    end

endmodule

`default_nettype wire

//--- hw/wall_palette.sv
`timescale 1ns/10ps
`default_nettype none

module wall_palette (
    input  wire                          pixel_clk_in,
    input  wire                          rst_in,
    input  wire raycast_pkg::sweep_beat_t beat,
    input  wire raycast_pkg::map_select_e map_select,
    output raycast_pkg::palette_t        colors
);

    raycast_pkg::color_t sky;
    raycast_pkg::color_t ground;
    raycast_pkg::color_t wall_color;
    logic                shade;

    // theme picks ceiling and floor
    always_comb begin
        case (map_select)
            raycast_pkg::HEDGE: begin
                sky    = raycast_pkg::SKY_HEDGE;
                ground = raycast_pkg::GROUND_HEDGE;
            end
            raycast_pkg::PIGS, raycast_pkg::DINO: begin
                sky    = raycast_pkg::SKY_DAY;
                ground = raycast_pkg::GROUND_DAY;
            end
            default: begin // neon
                sky    = raycast_pkg::SKY_NEON;
                ground = raycast_pkg::GROUND_NEON;
            end
        endcase
    end

    always_comb begin
        shade = beat.wall_type;
        case (beat.map_data)
            5'd0: begin
                wall_color = sky;   // empty cell shows through as sky
                shade      = 1'b0;
            end
            5'd23:   wall_color = raycast_pkg::NEON_YELLOW;
            5'd24:   wall_color = raycast_pkg::NEON_BLUE;
            5'd25:   wall_color = raycast_pkg::NEON_GREEN;
            5'd26:   wall_color = raycast_pkg::NEON_PINK;
            default: wall_color = raycast_pkg::SOLID_WALL; // incl. texture ids
        endcase
    end

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            colors <= '0;
        end else if (beat.valid) begin // hold between sweeps
            colors <= '{sky: sky, ground: ground, wall_color: wall_color, shade: shade};
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_writer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_writer #(
    parameter int SCREEN_WIDTH = 320
) (
    input  wire                          pixel_clk_in,
    input  wire                          rst_in,
    input  wire raycast_pkg::span_result_t span,
    input  wire raycast_pkg::palette_t    colors,
    output logic                         pixel_valid,
    output raycast_pkg::fb_addr_t        pixel_addr,
    output raycast_pkg::fb_pixel_t       pixel,
    output logic                         pixel_last
);

    localparam raycast_pkg::fb_addr_t ROW_STRIDE = raycast_pkg::fb_addr_t'(SCREEN_WIDTH);

    raycast_pkg::fb_pixel_t px_next;
    raycast_pkg::fb_addr_t  addr_next;

    always_comb begin
        case (span.region)
            raycast_pkg::CEILING: px_next = '{shade: 1'b0, color: colors.sky};
            raycast_pkg::FLOOR:   px_next = '{shade: 1'b0, color: colors.ground};
            default:              px_next = '{shade: colors.shade, color: colors.wall_color};
        endcase
        // row-major with one row of SCREEN_WIDTH words
        addr_next = raycast_pkg::fb_addr_t'(span.hcount)
                  + raycast_pkg::fb_addr_t'(span.row) * ROW_STRIDE;
    end

    always_ff @(posedge pixel_clk_in) begin
        pixel      <= px_next;
        pixel_addr <= addr_next;
        if (rst_in) begin
            pixel_valid <= 1'b0;
            pixel_last  <= 1'b0;
        end else begin
            pixel_valid <= span.valid;
            pixel_last  <= span.last;
        end
    end

endmodule

`default_nettype wire

//--- hw/column_flattener.sv
`timescale 1ns/10ps
`default_nettype none

module column_flattener #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180   // 2..255, width*height within 16 bits
) (
    input  wire                          pixel_clk_in,
    input  wire                          rst_in,
    input  wire                          column_tvalid,
    input  wire raycast_pkg::column_rec_t column_tdata,
    input  wire                          column_tlast,
    output logic                         column_tready,
    input  wire                          fb_switch_ready,
    input  wire raycast_pkg::map_select_e map_select,
    output logic                         pixel_valid,
    output raycast_pkg::fb_addr_t        pixel_addr,
    output raycast_pkg::fb_pixel_t       pixel,
    output logic                         pixel_last
);

    raycast_pkg::sweep_beat_t  beat;    // one row per cycle
    raycast_pkg::span_result_t span;    // region, one cycle later
    raycast_pkg::palette_t     colors;  // same stage as span

    column_intake #(.SCREEN_HEIGHT(SCREEN_HEIGHT)) intake0 (
        .pixel_clk_in   (pixel_clk_in),
        .rst_in         (rst_in),
        .column_tvalid  (column_tvalid),
        .column_tdata   (column_tdata),
        .column_tlast   (column_tlast),
        .fb_switch_ready(fb_switch_ready),
        .column_tready  (column_tready),
        .beat           (beat)
    );

    span_classifier #(.SCREEN_HEIGHT(SCREEN_HEIGHT)) classify0 (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .beat        (beat),
        .span        (span)
    );

    wall_palette palette0 (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .beat        (beat),
        .map_select  (map_select),
        .colors      (colors)
    );

    pixel_writer #(.SCREEN_WIDTH(SCREEN_WIDTH)) writer0 (
        .pixel_clk_in(pixel_clk_in),
        .rst_in      (rst_in),
        .span        (span),
        .colors      (colors),
        .pixel_valid (pixel_valid),
        .pixel_addr  (pixel_addr),
        .pixel       (pixel),
        .pixel_last  (pixel_last)
    );

endmodule

`default_nettype wire

//--- tests/column_flattener_sva.sv
`timescale 1ns/10ps
`default_nettype none

module column_flattener_sva #(
    parameter int SCREEN_HEIGHT = 180
) (
    input wire pixel_clk_in,
    input wire rst_in,
    input wire column_tvalid,
    input wire column_tready,
    input wire fb_switch_ready,
    input wire pixel_valid,
    input wire pixel_last
);

    int   sweep_left;  // beats left in the running sweep
    logic last_seen;   // packet closed, fb switch still owed

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            sweep_left <= 0;
            last_seen  <= 1'b0;
        end else begin
            if (column_tvalid && column_tready) begin
                sweep_left <= SCREEN_HEIGHT;
            end else if (sweep_left != 0) begin
                sweep_left <= sweep_left - 1;
            end
            if (fb_switch_ready) begin
                last_seen <= 1'b0;
            end else if (pixel_last) begin
                last_seen <= 1'b1;
            end
        end
    end

    last_has_valid: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        pixel_last |-> pixel_valid)
        else $error("pixel_last high without pixel_valid");

    ready_low_in_sweep: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        (sweep_left != 0) |-> !column_tready)
        else $error("column_tready high during a sweep");

    ready_low_until_switch: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
        last_seen |-> !column_tready)
        else $error("column_tready high before fb_switch_ready");

endmodule

bind column_flattener column_flattener_sva #(.SCREEN_HEIGHT(SCREEN_HEIGHT)) sva0 (
    .pixel_clk_in   (pixel_clk_in),
    .rst_in         (rst_in),
    .column_tvalid  (column_tvalid),
    .column_tready  (column_tready),
    .fb_switch_ready(fb_switch_ready),
    .pixel_valid    (pixel_valid),
    .pixel_last     (pixel_last)
);

`default_nettype wire

//--- tests/tb_column_flattener.sv
`timescale 1ns/10ps
`default_nettype none

module tb_column_flattener;

    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 180;
    localparam int NUM_RECS      = 48;

    logic                     pixel_clk_in;
    logic                     rst_in;
    logic                     column_tvalid;
    raycast_pkg::column_rec_t column_tdata;
    logic                     column_tlast;
    logic                     column_tready;
    logic                     fb_switch_ready;
    raycast_pkg::map_select_e map_select;
    logic                     pixel_valid;
    raycast_pkg::fb_addr_t    pixel_addr;
    raycast_pkg::fb_pixel_t   pixel;
    logic                     pixel_last;

    integer seed = 32'h10d2;

    raycast_pkg::fb_addr_t  exp_addr_q[$];  // expected pixel stream in order
    raycast_pkg::fb_pixel_t exp_pix_q[$];
    logic                   exp_last_q[$];
    int   sweep_left     = 0;     // beats the DUT still owes for the current record
    logic switch_pending = 1'b0;  // tlast record taken and fb not switched yet

    column_flattener dut0 (
        .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
        .column_tvalid(column_tvalid), .column_tdata(column_tdata),
        .column_tlast(column_tlast), .column_tready(column_tready),
        .fb_switch_ready(fb_switch_ready), .map_select(map_select),
        .pixel_valid(pixel_valid), .pixel_addr(pixel_addr),
        .pixel(pixel), .pixel_last(pixel_last)
    );

    always #5 pixel_clk_in = ~pixel_clk_in;  // 10 ns period

    task automatic halt_failed();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_addr(input string name, input raycast_pkg::fb_addr_t got,
                                input raycast_pkg::fb_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            halt_failed();
        end
    endtask

    task automatic compare_pixel(input string name, input raycast_pkg::fb_pixel_t got,
                                 input raycast_pkg::fb_pixel_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            halt_failed();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            halt_failed();
        end
    endtask

    // map cells drawn by the stimulus (empty, solid, texture id, neon set and out of range)
    function automatic raycast_pkg::map_cell_t cell_pick(input int idx);
        case (idx)
            0:       return 5'd0;
            1:       return 5'd1;
            2:       return 5'd5;
            3:       return 5'd23;
            4:       return 5'd24;
            5:       return 5'd25;
            6:       return 5'd26;
            default: return 5'd30;
        endcase
    endfunction

    // queue the SCREEN_HEIGHT pixels one record should produce
    task automatic push_record(input raycast_pkg::column_rec_t rec, input logic tl,
                               input raycast_pkg::map_select_e theme);
        int half;
        int mid;
        int dstart;
        int dend;
        raycast_pkg::color_t    sky;
        raycast_pkg::color_t    ground;
        raycast_pkg::color_t    wall_c;
        logic                   wall_shade;
        raycast_pkg::fb_pixel_t px;
        half   = int'(rec.line_height) / 2;
        mid    = SCREEN_HEIGHT / 2;
        dstart = (half > mid) ? 0 : mid - half;  // clamped top
        dend   = (mid + half > SCREEN_HEIGHT) ? SCREEN_HEIGHT : mid + half;
        case (theme)
            raycast_pkg::HEDGE: begin
                sky    = raycast_pkg::SKY_HEDGE;
                ground = raycast_pkg::GROUND_HEDGE;
            end
            raycast_pkg::NEON: begin
                sky    = raycast_pkg::SKY_NEON;
                ground = raycast_pkg::GROUND_NEON;
            end
            default: begin  // pigs and dino
                sky    = raycast_pkg::SKY_DAY;
                ground = raycast_pkg::GROUND_DAY;
            end
        endcase
        wall_shade = rec.wall_type;
        case (rec.map_data)
            5'd0: begin
                wall_c     = sky;
                wall_shade = 1'b0;
            end
            5'd23:   wall_c = raycast_pkg::NEON_YELLOW;
            5'd24:   wall_c = raycast_pkg::NEON_BLUE;
            5'd25:   wall_c = raycast_pkg::NEON_GREEN;
            5'd26:   wall_c = raycast_pkg::NEON_PINK;
            default: wall_c = raycast_pkg::SOLID_WALL;
        endcase
        for (int r = 0; r < SCREEN_HEIGHT; r++) begin
            if (r < dstart) begin
                px.shade = 1'b0;
                px.color = sky;
            end else if (r >= dend) begin
                px.shade = 1'b0;
                px.color = ground;
            end else begin
                px.shade = wall_shade;
                px.color = wall_c;
            end
            exp_addr_q.push_back(raycast_pkg::fb_addr_t'(int'(rec.hcount) + r * SCREEN_WIDTH));
            exp_pix_q.push_back(px);
            exp_last_q.push_back(tl && (r == SCREEN_HEIGHT - 1));
        end
    endtask

    // model and checks sampled at the rising edge
    always @(posedge pixel_clk_in) begin
        if (!rst_in) begin
            compare_bit("column_tready", column_tready, (sweep_left == 0) && !switch_pending);
            if (pixel_valid) begin
                if (exp_addr_q.size() == 0) begin
                    $display("pixel_valid went high with no pixel left to expect");
                    halt_failed();
                end else begin
                    compare_addr("pixel_addr", pixel_addr, exp_addr_q.pop_front());
                    compare_pixel("pixel", pixel, exp_pix_q.pop_front());
                    compare_bit("pixel_last", pixel_last, exp_last_q.pop_front());
                end
            end else begin
                compare_bit("pixel_last", pixel_last, 1'b0);
            end
            if (switch_pending && fb_switch_ready) begin
                switch_pending = 1'b0;
            end
            if (column_tvalid && column_tready) begin
                push_record(column_tdata, column_tlast, map_select);
                sweep_left     = SCREEN_HEIGHT;
                switch_pending = column_tlast;
            end else if (sweep_left != 0) begin
                sweep_left = sweep_left - 1;
            end
        end
    end

    // frame buffer side picks a new theme per packet and pulses the switch 1..20 cycles later
    always @(posedge pixel_clk_in) begin
        int delay;
        if (!rst_in && pixel_last) begin
            map_select <= raycast_pkg::map_select_e'(2'($random(seed)));
            delay = 1 + {$random(seed)} % 20;
            repeat (delay) @(posedge pixel_clk_in);
            fb_switch_ready <= 1'b1;
            @(posedge pixel_clk_in);
            fb_switch_ready <= 1'b0;
        end
    end

    initial begin
        int pick;
        int gap;
        raycast_pkg::column_rec_t rec;
        pixel_clk_in    = 1'b0;
        rst_in          = 1'b1;
        column_tvalid   = 1'b0;
        column_tdata    = '0;
        column_tlast    = 1'b0;
        fb_switch_ready = 1'b0;
        map_select      = raycast_pkg::map_select_e'(2'($random(seed)));
        repeat (3) @(posedge pixel_clk_in);
        rst_in <= 1'b0;
        @(posedge pixel_clk_in);
        compare_bit("column_tready", column_tready, 1'b1);  // reset state
        compare_bit("pixel_valid", pixel_valid, 1'b0);
        compare_bit("pixel_last", pixel_last, 1'b0);
        for (int i = 0; i < NUM_RECS; i++) begin
            pick = {$random(seed)} % 8;
            gap  = (pick < 4) ? 0 : pick - 3;  // half the records back to back
            repeat (gap) begin
                column_tvalid <= 1'b0;
                @(posedge pixel_clk_in);
            end
            rec.hcount      = raycast_pkg::hcount_t'({$random(seed)} % SCREEN_WIDTH);
            rec.line_height = 8'($random(seed));
            rec.wall_type   = 1'($random(seed));
            rec.map_data    = cell_pick({$random(seed)} % 8);
            rec.wall_x      = 16'($random(seed));
            column_tdata  <= rec;
            column_tlast  <= (i == NUM_RECS - 1) || ({$random(seed)} % 4 == 0);
            column_tvalid <= 1'b1;
            do @(posedge pixel_clk_in); while (!(column_tvalid && column_tready));
        end
        column_tvalid <= 1'b0;
        while (exp_addr_q.size() != 0 || switch_pending) @(posedge pixel_clk_in);
        repeat (4) @(posedge pixel_clk_in);  // room for any stray pixel
        $display("All tests passed");
        $finish;
    end

    initial begin
        repeat (NUM_RECS * (SCREEN_HEIGHT + 40)) @(posedge pixel_clk_in);
        $display("timeout: the run did not finish within the cycle budget");
        halt_failed();
    end

endmodule

`default_nettype wire

//--- list.f
hw/raycast_pkg.sv
hw/column_intake.sv
hw/span_classifier.sv
hw/wall_palette.sv
hw/pixel_writer.sv
hw/column_flattener.sv
tests/column_flattener_sva.sv
tests/tb_column_flattener.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the column flattener testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_column_flattener \
    -Mdir obj_dir -o sim_column_flattener \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_column_flattener
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
